// File: rv_pkg.sv
package rv_pkg;

localparam int xlen = 32;

typedef logic [xlen-1:0] word_t;
typedef logic [4:0]      reg_idx_t;
typedef logic [3:0]      alu_ctrl_t;
typedef logic [2:0]      imm_src_t;
typedef logic [1:0]      result_src_t;
typedef logic [2:0]      funct3_t;
typedef logic [6:0]      opcode_t;

// ------------------------------
// RV32I base opcodes
localparam opcode_t op_r      = 7'b0110011;
localparam opcode_t op_i_alu  = 7'b0010011;
localparam opcode_t op_load   = 7'b0000011;
localparam opcode_t op_store  = 7'b0100011;
localparam opcode_t op_branch = 7'b1100011;
localparam opcode_t op_jal    = 7'b1101111;
localparam opcode_t op_jalr   = 7'b1100111;
localparam opcode_t op_lui    = 7'b0110111;
localparam opcode_t op_auipc  = 7'b0010111;

// ------------------------------
// ALU operations seen by execute
localparam alu_ctrl_t alu_add    = 4'd0;
localparam alu_ctrl_t alu_sub    = 4'd1;
localparam alu_ctrl_t alu_and    = 4'd2;
localparam alu_ctrl_t alu_or     = 4'd3;
localparam alu_ctrl_t alu_xor    = 4'd4;
localparam alu_ctrl_t alu_sll    = 4'd5;
localparam alu_ctrl_t alu_srl    = 4'd6;
localparam alu_ctrl_t alu_sra    = 4'd7;
localparam alu_ctrl_t alu_slt    = 4'd8;
localparam alu_ctrl_t alu_sltu   = 4'd9;
localparam alu_ctrl_t alu_pass_b = 4'd10;   // Result is operand B, used by lui

// Immediate formats
localparam imm_src_t imm_i = 3'd0;
localparam imm_src_t imm_s = 3'd1;
localparam imm_src_t imm_b = 3'd2;
localparam imm_src_t imm_j = 3'd3;
localparam imm_src_t imm_u = 3'd4;

// Writeback source select
localparam result_src_t res_alu = 2'd0;
localparam result_src_t res_mem = 2'd1;
localparam result_src_t res_pc4 = 2'd2;   // Link address for jal and jalr

endpackage

// File: control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  rv_pkg::word_t       instr,

    output logic                reg_write,
    output rv_pkg::result_src_t result_src,
    output logic                mem_write,
    output logic                branch,
    output logic                jump,
    output logic                jalr,
    output rv_pkg::alu_ctrl_t   alu_control,
    output logic                alu_src,
    output rv_pkg::imm_src_t    imm_src,
    output rv_pkg::funct3_t     funct3,
    output logic                illegal
);

rv_pkg::opcode_t   opcode;
logic              funct7_b5;
rv_pkg::alu_ctrl_t alu_funct;   // ALU code implied by funct3 and funct7
logic [11:0]       ctrl;

assign opcode    = instr[6:0];
assign funct3    = instr[14:12];
assign funct7_b5 = instr[30];

// ------------------------------
// Main decoder
// Fields: reg_write, result_src, mem_write/branch/jump/jalr, alu_src, imm_src, illegal
always_comb begin
    case (opcode)
        rv_pkg::op_r:      ctrl = {1'b1, rv_pkg::res_alu, 4'b0000, 1'b0, rv_pkg::imm_i, 1'b0};
        rv_pkg::op_i_alu:  ctrl = {1'b1, rv_pkg::res_alu, 4'b0000, 1'b1, rv_pkg::imm_i, 1'b0};
        rv_pkg::op_load:   ctrl = {1'b1, rv_pkg::res_mem, 4'b0000, 1'b1, rv_pkg::imm_i, 1'b0};
        rv_pkg::op_store:  ctrl = {1'b0, rv_pkg::res_alu, 4'b1000, 1'b1, rv_pkg::imm_s, 1'b0};
        rv_pkg::op_branch: ctrl = {1'b0, rv_pkg::res_alu, 4'b0100, 1'b0, rv_pkg::imm_b, 1'b0};
        rv_pkg::op_jal:    ctrl = {1'b1, rv_pkg::res_pc4, 4'b0010, 1'b0, rv_pkg::imm_j, 1'b0};
        rv_pkg::op_jalr:   ctrl = {1'b1, rv_pkg::res_pc4, 4'b0011, 1'b1, rv_pkg::imm_i, 1'b0};
        rv_pkg::op_lui:    ctrl = {1'b1, rv_pkg::res_alu, 4'b0000, 1'b1, rv_pkg::imm_u, 1'b0};
        rv_pkg::op_auipc:  ctrl = {1'b1, rv_pkg::res_alu, 4'b0000, 1'b1, rv_pkg::imm_u, 1'b0};
        default:           ctrl = {1'b0, rv_pkg::res_alu, 4'b0000, 1'b0, rv_pkg::imm_i, 1'b1};
    endcase
end

assign {reg_write, result_src, mem_write, branch, jump, jalr, alu_src, imm_src, illegal} = ctrl;

// ------------------------------
// ALU decoder
always_comb begin
    case (funct3)
        3'b000:  alu_funct = (opcode == rv_pkg::op_r && funct7_b5) ? rv_pkg::alu_sub
                                                                   : rv_pkg::alu_add;
        3'b001:  alu_funct = rv_pkg::alu_sll;
        3'b010:  alu_funct = rv_pkg::alu_slt;
        3'b011:  alu_funct = rv_pkg::alu_sltu;
        3'b100:  alu_funct = rv_pkg::alu_xor;
        3'b101:  alu_funct = funct7_b5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        3'b110:  alu_funct = rv_pkg::alu_or;
        default: alu_funct = rv_pkg::alu_and;
    endcase
end

always_comb begin
    case (opcode)
        rv_pkg::op_r,
        rv_pkg::op_i_alu:  alu_control = alu_funct;
        rv_pkg::op_branch: alu_control = rv_pkg::alu_sub;      // Execute compares via the difference
        rv_pkg::op_lui:    alu_control = rv_pkg::alu_pass_b;
        default:           alu_control = rv_pkg::alu_add;      // Address and auipc sums
    endcase
end

endmodule

// File: sign_extend.sv
`timescale 1ns/100ps

module sign_extend (
    input  rv_pkg::imm_src_t imm_src,
    input  rv_pkg::word_t    instr,

    output rv_pkg::word_t    imm_ext
);

logic sign;

assign sign = instr[31];   // Every format keeps its sign in bit 31

always_comb begin
    case (imm_src)
        rv_pkg::imm_i: imm_ext = {{20{sign}}, instr[31:20]};
        rv_pkg::imm_s: imm_ext = {{20{sign}}, instr[31:25], instr[11:7]};
        // Branch and jump offsets are in half-words, so bit 0 is always zero
        rv_pkg::imm_b: imm_ext = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        rv_pkg::imm_j: imm_ext = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        rv_pkg::imm_u: imm_ext = {instr[31:12], 12'h000};
        default:       imm_ext = '0;
    endcase
end

endmodule

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic             clk,
    input  logic             wr_en,
    input  rv_pkg::reg_idx_t wr_addr,
    input  rv_pkg::word_t    wr_data,
    input  rv_pkg::reg_idx_t rd_addr1,
    input  rv_pkg::reg_idx_t rd_addr2,

    output rv_pkg::word_t    rd_data1,
    output rv_pkg::word_t    rd_data2,
    output rv_pkg::word_t    a0
);

rv_pkg::word_t regs [1:31];   // x0 has no storage
logic          wr_live;

assign wr_live = wr_en && (wr_addr != '0);

always_ff @(posedge clk) begin
    if (wr_live) begin
        regs[wr_addr] <= wr_data;
    end
end

// Write-through so decode sees a result retiring in the same cycle
function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t addr);
    if (addr == '0)
        return '0;
    else if (wr_live && (addr == wr_addr))
        return wr_data;
    else
        return regs[addr];
endfunction

always_comb begin
    rd_data1 = read_port(rd_addr1);
    rd_data2 = read_port(rd_addr2);
    a0       = read_port(5'd10);
end

// A write aimed at x0 never becomes visible on a later read
a_x0_zero: assert property (@(posedge clk)
    (wr_en && wr_addr == '0) |=> ((rd_addr1 != '0 || rd_data1 == '0) &&
                                  (rd_addr2 != '0 || rd_data2 == '0)))
    else $error("reg_file: x0 read back nonzero after a write to it");

endmodule

// File: decode.sv
`timescale 1ns/100ps

module decode (
    input  logic                clk,
    input  rv_pkg::word_t       instr_d,
    input  logic                reg_write_w,
    input  rv_pkg::reg_idx_t    rd_w,
    input  rv_pkg::word_t       result_w,

    output rv_pkg::reg_idx_t    rd_d,
    output rv_pkg::reg_idx_t    rs1_d,
    output rv_pkg::reg_idx_t    rs2_d,
    output logic                reg_write_d,
    output rv_pkg::result_src_t result_src_d,
    output logic                mem_write_d,
    output logic                branch_d,
    output logic                jump_d,
    output logic                jalr_d,
    output rv_pkg::alu_ctrl_t   alu_control_d,
    output logic                alu_src_d,
    output rv_pkg::funct3_t     funct3_d,
    output logic                illegal_d,
    output rv_pkg::word_t       rd1_d,
    output rv_pkg::word_t       rd2_d,
    output rv_pkg::word_t       imm_ext_d,
    output rv_pkg::word_t       a0
);

rv_pkg::imm_src_t imm_src_d;

// Register fields sit at the same place in every format
assign rd_d  = instr_d[11:7];
assign rs1_d = instr_d[19:15];
assign rs2_d = instr_d[24:20];

control_unit cu (
    .instr       (instr_d),
    .reg_write   (reg_write_d),
    .result_src  (result_src_d),
    .mem_write   (mem_write_d),
    .branch      (branch_d),
    .jump        (jump_d),
    .jalr        (jalr_d),
    .alu_control (alu_control_d),
    .alu_src     (alu_src_d),
    .imm_src     (imm_src_d),
    .funct3      (funct3_d),
    .illegal     (illegal_d)
);

reg_file rf (
    .clk         (clk),
    .wr_en       (reg_write_w),
    .wr_addr     (rd_w),
    .wr_data     (result_w),
    .rd_addr1    (rs1_d),
    .rd_addr2    (rs2_d),
    .rd_data1    (rd1_d),
    .rd_data2    (rd2_d),
    .a0          (a0)
);

sign_extend se (
    .imm_src     (imm_src_d),
    .instr       (instr_d),
    .imm_ext     (imm_ext_d)
);

endmodule

// File: hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic                valid_d,
    input  rv_pkg::reg_idx_t    rs1_d,
    input  rv_pkg::reg_idx_t    rs2_d,
    input  logic                valid_e,
    input  rv_pkg::reg_idx_t    rd_e,
    input  rv_pkg::result_src_t result_src_e,

    output logic                stall
);

logic load_e;     // A live load sits in execute
logic src_match;

assign load_e = valid_e && (result_src_e == rv_pkg::res_mem) && (rd_e != '0);

// rs2 is compared even for formats without one, costing a spare stall at worst
assign src_match = (rd_e == rs1_d) || (rd_e == rs2_d);

assign stall = valid_d && load_e && src_match;

endmodule

// File: if_id_reg.sv
`timescale 1ns/100ps

module if_id_reg (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  logic          valid_f,
    input  rv_pkg::word_t instr_f,
    input  rv_pkg::word_t pc_f,

    output logic          valid_d,
    output rv_pkg::word_t instr_d,
    output rv_pkg::word_t pc_d,
    output rv_pkg::word_t pc_plus4_d
);

always_ff @(posedge clk) begin
    if (reset || flush) begin   // Redirect wins over a stall
        valid_d <= 1'b0;
    end else if (!stall) begin
        valid_d <= valid_f;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        instr_d    <= instr_f;
        pc_d       <= pc_f;
        pc_plus4_d <= pc_f + rv_pkg::word_t'(4);
    end
end

endmodule

// File: id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                bubble,

    input  logic                valid_d,
    input  logic                reg_write_d,
    input  rv_pkg::result_src_t result_src_d,
    input  logic                mem_write_d,
    input  logic                branch_d,
    input  logic                jump_d,
    input  logic                jalr_d,
    input  rv_pkg::alu_ctrl_t   alu_control_d,
    input  logic                alu_src_d,
    input  rv_pkg::funct3_t     funct3_d,
    input  logic                illegal_d,
    input  rv_pkg::word_t       rd1_d,
    input  rv_pkg::word_t       rd2_d,
    input  rv_pkg::word_t       imm_ext_d,
    input  rv_pkg::word_t       pc_d,
    input  rv_pkg::word_t       pc_plus4_d,
    input  rv_pkg::reg_idx_t    rd_d,
    input  rv_pkg::reg_idx_t    rs1_d,
    input  rv_pkg::reg_idx_t    rs2_d,

    output logic                valid_e,
    output logic                reg_write_e,
    output rv_pkg::result_src_t result_src_e,
    output logic                mem_write_e,
    output logic                branch_e,
    output logic                jump_e,
    output logic                jalr_e,
    output rv_pkg::alu_ctrl_t   alu_control_e,
    output logic                alu_src_e,
    output rv_pkg::funct3_t     funct3_e,
    output logic                illegal_e,
    output rv_pkg::word_t       rd1_e,
    output rv_pkg::word_t       rd2_e,
    output rv_pkg::word_t       imm_ext_e,
    output rv_pkg::word_t       pc_e,
    output rv_pkg::word_t       pc_plus4_e,
    output rv_pkg::reg_idx_t    rd_e,
    output rv_pkg::reg_idx_t    rs1_e,
    output rv_pkg::reg_idx_t    rs2_e
);

// ------------------------------
// Valid bit and enables
always_ff @(posedge clk) begin
    if (reset || flush || bubble) begin
        valid_e     <= 1'b0;
        reg_write_e <= 1'b0;
        mem_write_e <= 1'b0;
        branch_e    <= 1'b0;
        jump_e      <= 1'b0;
        jalr_e      <= 1'b0;
        illegal_e   <= 1'b0;
    end else begin
        valid_e     <= valid_d;
        reg_write_e <= reg_write_d && valid_d;   // An empty decode slot carries no side effects
        mem_write_e <= mem_write_d && valid_d;
        branch_e    <= branch_d && valid_d;
        jump_e      <= jump_d && valid_d;
        jalr_e      <= jalr_d && valid_d;
        illegal_e   <= illegal_d && valid_d;
    end
end

// Operands and decoded fields travel with the instruction
always_ff @(posedge clk) begin
    result_src_e  <= result_src_d;
    alu_control_e <= alu_control_d;
    alu_src_e     <= alu_src_d;
    funct3_e      <= funct3_d;
    rd1_e         <= rd1_d;
    rd2_e         <= rd2_d;
    imm_ext_e     <= imm_ext_d;
    pc_e          <= pc_d;
    pc_plus4_e    <= pc_plus4_d;
    rd_e          <= rd_d;
    rs1_e         <= rs1_d;
    rs2_e         <= rs2_d;
end

// ------------------------------
// Checks
a_idle_no_enable: assert property (@(posedge clk) disable iff (reset)
    !valid_e |-> !(reg_write_e || mem_write_e || branch_e || jump_e || jalr_e || illegal_e))
    else $error("id_ex_reg: enable set while valid_e is low");

// Control unit must drop every enable on an unknown opcode
a_illegal_no_write: assert property (@(posedge clk) disable iff (reset)
    !(illegal_e && reg_write_e))
    else $error("id_ex_reg: illegal instruction carries reg_write");

endmodule

// File: decode_top.sv
`timescale 1ns/100ps

module decode_top (
    input  logic                clk,
    input  logic                reset,

    input  logic                valid_f,
    input  rv_pkg::word_t       instr_f,
    input  rv_pkg::word_t       pc_f,
    output logic                stall_f,   // Fetch holds its outputs while high

    input  logic                redirect_e,
    input  logic                reg_write_w,
    input  rv_pkg::reg_idx_t    rd_w,
    input  rv_pkg::word_t       result_w,

    output logic                valid_e,
    output logic                reg_write_e,
    output rv_pkg::result_src_t result_src_e,
    output logic                mem_write_e,
    output logic                branch_e,
    output logic                jump_e,
    output logic                jalr_e,
    output rv_pkg::alu_ctrl_t   alu_control_e,
    output logic                alu_src_e,
    output rv_pkg::funct3_t     funct3_e,
    output logic                illegal_e,
    output rv_pkg::word_t       rd1_e,
    output rv_pkg::word_t       rd2_e,
    output rv_pkg::word_t       imm_ext_e,
    output rv_pkg::word_t       pc_e,
    output rv_pkg::word_t       pc_plus4_e,
    output rv_pkg::reg_idx_t    rd_e,
    output rv_pkg::reg_idx_t    rs1_e,
    output rv_pkg::reg_idx_t    rs2_e,
    output rv_pkg::word_t       a0
);

// ------------------------------
// Decode stage signals
logic                valid_d;
rv_pkg::word_t       instr_d;
rv_pkg::word_t       pc_d;
rv_pkg::word_t       pc_plus4_d;
rv_pkg::reg_idx_t    rd_d;
rv_pkg::reg_idx_t    rs1_d;
rv_pkg::reg_idx_t    rs2_d;
logic                reg_write_d;
rv_pkg::result_src_t result_src_d;
logic                mem_write_d;
logic                branch_d;
logic                jump_d;
logic                jalr_d;
rv_pkg::alu_ctrl_t   alu_control_d;
logic                alu_src_d;
rv_pkg::funct3_t     funct3_d;
logic                illegal_d;
rv_pkg::word_t       rd1_d;
rv_pkg::word_t       rd2_d;
rv_pkg::word_t       imm_ext_d;

// Port names match the stage signals, only stall and flush are renamed
if_id_reg if_id (
    .stall (stall_f),
    .flush (redirect_e),
    .*
);

decode dec (.*);

hazard_unit hz (
    .stall (stall_f),
    .*
);

// The load-use stall holds IF/ID and turns the ID/EX load into a bubble
id_ex_reg id_ex (
    .flush  (redirect_e),
    .bubble (stall_f),
    .*
);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
end

initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #10 reset = 1'b0;
end

endmodule

// File: tb_decode_top.sv
`timescale 1ns/100ps

module tb_decode_top;

localparam int max_rows = 40;

// Control patterns as reg_write, result_src, mem_write, branch, jump, jalr, alu_src, illegal
localparam logic [8:0] c_r    = 9'b1_00_0000_0_0;
localparam logic [8:0] c_i    = 9'b1_00_0000_1_0;
localparam logic [8:0] c_lw   = 9'b1_01_0000_1_0;
localparam logic [8:0] c_sw   = 9'b0_00_1000_1_0;
localparam logic [8:0] c_br   = 9'b0_00_0100_0_0;
localparam logic [8:0] c_jal  = 9'b1_10_0010_0_0;
localparam logic [8:0] c_jalr = 9'b1_10_0011_1_0;
localparam logic [8:0] c_ill  = 9'b0_00_0000_0_1;

logic clk, reset;
logic valid_f, stall_f, redirect_e, reg_write_w;
rv_pkg::word_t instr_f, pc_f, result_w;
rv_pkg::reg_idx_t rd_w;
logic valid_e, reg_write_e, mem_write_e, branch_e, jump_e, jalr_e, alu_src_e, illegal_e;
rv_pkg::result_src_t result_src_e;
rv_pkg::alu_ctrl_t alu_control_e;
rv_pkg::funct3_t funct3_e;
rv_pkg::word_t rd1_e, rd2_e, imm_ext_e, pc_e, pc_plus4_e, a0;
rv_pkg::reg_idx_t rd_e, rs1_e, rs2_e;

// ------------------------------
// Stimulus and expected values
logic              t_wb_en   [max_rows];
rv_pkg::reg_idx_t  t_wb_rd   [max_rows];
rv_pkg::word_t     t_wb_data [max_rows];
logic              t_valid   [max_rows];
rv_pkg::word_t     t_instr   [max_rows];
rv_pkg::word_t     t_pc      [max_rows];
logic              t_redir   [max_rows];
logic [8:0]        t_ctrl    [max_rows];
rv_pkg::alu_ctrl_t t_alu     [max_rows];
rv_pkg::funct3_t   t_f3      [max_rows];
logic              t_chk_imm [max_rows];
rv_pkg::word_t     t_imm     [max_rows];

int n_rows, errors, checks, cycles, limit;
int row_i, cur_row, seed_i, drain, d_row, e_row;
logic d_v, e_v, last_stall, done, in_reset;
rv_pkg::word_t e_rd1, e_rd2;
rv_pkg::word_t mirror [32];

tb_clock_gen clock_gen (.clk(clk), .reset(reset));

decode_top DUT (.*);

task automatic add_row(input logic wb_en, input int wb_rd, input rv_pkg::word_t wb_data,
                       input logic valid, input rv_pkg::word_t instr, input logic redir,
                       input logic [8:0] ctrl, input rv_pkg::alu_ctrl_t alu,
                       input int f3, input logic chk_imm, input rv_pkg::word_t imm);
    t_wb_en[n_rows]   = wb_en;
    t_wb_rd[n_rows]   = wb_rd;
    t_wb_data[n_rows] = wb_data;
    t_valid[n_rows]   = valid;
    t_instr[n_rows]   = instr;
    t_pc[n_rows]      = 32'h0000_1000 + 4 * n_rows;
    t_redir[n_rows]   = redir;
    t_ctrl[n_rows]    = ctrl;
    t_alu[n_rows]     = alu;
    t_f3[n_rows]      = f3;
    t_chk_imm[n_rows] = chk_imm;
    t_imm[n_rows]     = imm;
    n_rows++;
endtask

// Load-use rule applied to the model's decode and execute slots
function automatic logic model_stall();
    rv_pkg::reg_idx_t rde;
    rv_pkg::word_t    ins;
    if (!d_v || !e_v)
        return 1'b0;
    rde = t_instr[e_row][11:7];
    ins = t_instr[d_row];
    return t_ctrl[e_row][7:6] == rv_pkg::res_mem && rde != 0 &&
           (rde == ins[19:15] || rde == ins[24:20]);
endfunction

function automatic rv_pkg::word_t read_mirror(input rv_pkg::reg_idx_t r);
    if (r == 0)
        return '0;
    if (reg_write_w && rd_w == r)
        return result_w;   // Write-through
    return mirror[r];
endfunction

task automatic model_clock();
    last_stall = model_stall();
    if (reset || redirect_e) begin
        d_v = 1'b0;
        e_v = 1'b0;
    end else if (last_stall) begin
        e_v = 1'b0;   // Bubble while decode holds
    end else begin
        e_v   = d_v;
        e_row = d_row;
        if (d_v) begin
            e_rd1 = read_mirror(t_instr[d_row][19:15]);
            e_rd2 = read_mirror(t_instr[d_row][24:20]);
        end
        d_v   = valid_f;
        d_row = cur_row;
    end
    if (reg_write_w && rd_w != 0)
        mirror[rd_w] = result_w;
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_outputs();
    logic [8:0] c;
    check_val("stall_f", stall_f, model_stall());
    checks++;
    if (e_v && valid_e !== 1'b1) begin
        errors++;
        $display("Instruction of row %0d did not appear on valid_e", e_row);
    end else if (!e_v && valid_e !== 1'b0) begin
        errors++;
        $display("valid_e was high while no instruction was due");
    end
    c = e_v ? t_ctrl[e_row] : 9'b0_00_0000_0_0;
    check_val("reg_write_e", reg_write_e, c[8]);
    check_val("mem_write_e", mem_write_e, c[5]);
    check_val("branch_e", branch_e, c[4]);
    check_val("jump_e", jump_e, c[3]);
    check_val("jalr_e", jalr_e, c[2]);
    check_val("illegal_e", illegal_e, c[0]);
    if (e_v) begin
        check_val("result_src_e", result_src_e, c[7:6]);
        check_val("alu_src_e", alu_src_e, c[1]);
        check_val("alu_control_e", alu_control_e, t_alu[e_row]);
        check_val("funct3_e", funct3_e, t_f3[e_row]);
        if (t_chk_imm[e_row])
            check_val("imm_ext_e", imm_ext_e, t_imm[e_row]);
        check_val("pc_e", pc_e, t_pc[e_row]);
        check_val("pc_plus4_e", pc_plus4_e, t_pc[e_row] + 4);
        check_val("rd_e", rd_e, t_instr[e_row][11:7]);
        check_val("rs1_e", rs1_e, t_instr[e_row][19:15]);
        check_val("rs2_e", rs2_e, t_instr[e_row][24:20]);
        check_val("rd1_e", rd1_e, e_rd1);
        check_val("rd2_e", rd2_e, e_rd2);
    end
endtask

task automatic drive_idle();
    valid_f     = 1'b0;
    instr_f     = '0;
    pc_f        = '0;
    redirect_e  = 1'b0;
    reg_write_w = 1'b0;
    rd_w        = '0;
    result_w    = '0;
    cur_row     = -1;
endtask

task automatic present_row(input int r, input logic fresh);
    valid_f     = t_valid[r];
    instr_f     = t_instr[r];
    pc_f        = t_pc[r];
    redirect_e  = t_redir[r];
    reg_write_w = t_wb_en[r] && fresh;   // A held row does not write back twice
    rd_w        = t_wb_rd[r];
    result_w    = t_wb_data[r];
    cur_row     = r;
endtask

// ------------------------------
// Table
task automatic build_table();
    add_row(0, 0, 0,        1, 32'h002081B3, 0, c_r, rv_pkg::alu_add, 0, 0, 0);
    add_row(1, 1, $urandom, 1, 32'h40208233, 0, c_r, rv_pkg::alu_sub, 0, 0, 0);
    add_row(0, 0, 0,        1, 32'h007312B3, 0, c_r, rv_pkg::alu_sll, 1, 0, 0);
    add_row(1, 10, $urandom, 1, 32'h0020A2B3, 0, c_r, rv_pkg::alu_slt, 2, 0, 0);
    add_row(0, 0, 0,        1, 32'h0020B2B3, 0, c_r, rv_pkg::alu_sltu, 3, 0, 0);
    add_row(0, 0, 0,        1, 32'h0020C2B3, 0, c_r, rv_pkg::alu_xor, 4, 0, 0);
    add_row(0, 0, 0,        1, 32'h0020D2B3, 0, c_r, rv_pkg::alu_srl, 5, 0, 0);
    add_row(0, 0, 0,        1, 32'h4020D2B3, 0, c_r, rv_pkg::alu_sra, 5, 0, 0);
    add_row(0, 0, 0,        1, 32'h0020E2B3, 0, c_r, rv_pkg::alu_or, 6, 0, 0);
    add_row(0, 0, 0,        1, 32'h0020F2B3, 0, c_r, rv_pkg::alu_and, 7, 0, 0);
    add_row(0, 0, 0,        1, 32'hFFF08313, 0, c_i, rv_pkg::alu_add, 0, 1, 32'hFFFFFFFF);
    add_row(0, 0, 0,        1, 32'h12310393, 0, c_i, rv_pkg::alu_add, 0, 1, 32'h00000123);
    add_row(0, 0, 0,        1, 32'h4030D413, 0, c_i, rv_pkg::alu_sra, 5, 1, 32'h00000403);
    add_row(0, 0, 0,        1, 32'h00309413, 0, c_i, rv_pkg::alu_sll, 1, 1, 32'h00000003);
    // The second of these and the redirect row are flushed before reaching execute
    add_row(0, 0, 0,        1, 32'h0020F2B3, 0, c_r, rv_pkg::alu_and, 7, 0, 0);
    add_row(0, 0, 0,        1, 32'h12310393, 0, c_i, rv_pkg::alu_add, 0, 1, 32'h00000123);
    add_row(0, 0, 0,        1, 32'h00000013, 1, c_i, rv_pkg::alu_add, 0, 0, 0);
    add_row(0, 0, 0,        1, 32'hFFC12483, 0, c_lw, rv_pkg::alu_add, 2, 1, 32'hFFFFFFFC);
    add_row(0, 0, 0,        1, 32'h00148533, 0, c_r, rv_pkg::alu_add, 0, 0, 0);
    add_row(0, 0, 0,        1, 32'h0080A003, 0, c_lw, rv_pkg::alu_add, 2, 1, 32'h00000008);
    add_row(0, 0, 0,        1, 32'h000005B3, 0, c_r, rv_pkg::alu_add, 0, 0, 0);
    // Writes x0 and then reads it back through rs1
    add_row(1, 0, $urandom, 1, 32'h00202623, 0, c_sw, rv_pkg::alu_add, 2, 1, 32'h0000000C);
    add_row(0, 0, 0,        1, 32'hFE30AC23, 0, c_sw, rv_pkg::alu_add, 2, 1, 32'hFFFFFFF8);
    add_row(0, 0, 0,        1, 32'h00208863, 0, c_br, rv_pkg::alu_sub, 0, 1, 32'h00000010);
    add_row(0, 0, 0,        1, 32'hFE209CE3, 0, c_br, rv_pkg::alu_sub, 1, 1, 32'hFFFFFFF8);
    add_row(0, 0, 0,        1, 32'h0020E863, 0, c_br, rv_pkg::alu_sub, 6, 1, 32'h00000010);
    add_row(0, 0, 0,        1, 32'h001000EF, 0, c_jal, rv_pkg::alu_add, 0, 1, 32'h00000800);
    add_row(0, 0, 0,        1, 32'hFFDFF06F, 0, c_jal, rv_pkg::alu_add, 7, 1, 32'hFFFFFFFC);
    add_row(0, 0, 0,        1, 32'h004280E7, 0, c_jalr, rv_pkg::alu_add, 0, 1, 32'h00000004);
    add_row(0, 0, 0,        1, 32'h80000637, 0, c_i, rv_pkg::alu_pass_b, 0, 1, 32'h80000000);
    add_row(0, 0, 0,        1, 32'h12345697, 0, c_i, rv_pkg::alu_add, 5, 1, 32'h12345000);
    add_row(0, 0, 0,        1, 32'h0000007F, 0, c_ill, rv_pkg::alu_add, 0, 0, 0);
endtask

// ------------------------------
// Main sequence
initial begin
    errors = 0;
    checks = 0;
    n_rows = 0;
    void'($urandom(90123));
    drive_idle();
    foreach (mirror[i])
        mirror[i] = '0;
    build_table();
    limit  = 4 * n_rows + 50;
    d_v    = 1'b0;
    e_v    = 1'b0;
    d_row  = -1;
    e_row  = -1;
    row_i  = -1;
    seed_i = 1;
    drain  = 0;
    done   = 1'b0;
    last_stall = 1'b0;
    while (!done) begin
        @(posedge clk);
        in_reset = reset;
        model_clock();
        #1 check_outputs();
        #9 drive_idle();
        if (in_reset) begin
            // Nothing is driven while reset is high
        end else if (seed_i < 32) begin
            reg_write_w = 1'b1;   // Fill every register with a random value
            rd_w        = seed_i;
            result_w    = $urandom;
            seed_i++;
        end else if (row_i < n_rows - 1 || last_stall) begin
            if (!last_stall)
                row_i++;
            present_row(row_i, !last_stall);
        end else begin
            drain++;
            if (drain > 4)
                done = 1'b1;
        end
        #1;
        if (row_i >= 0)
            check_val("a0", a0, read_mirror(5'd10));   // Sees a write to x10 before it lands
    end
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
        $display("test passed");
    else
        $display("test failed");
    $finish;
end

always @(posedge clk) begin
    cycles++;
    if (n_rows > 0 && cycles > limit) begin
        $display("Run did not finish within %0d cycles", limit);
        $display("test failed");
        $finish;
    end
end

initial cycles = 0;

endmodule

// File: vlog.f
rv_pkg.sv
control_unit.sv
sign_extend.sv
reg_file.sv
decode.sv
hazard_unit.sv
if_id_reg.sv
id_ex_reg.sv
decode_top.sv
tb_clock_gen.sv
tb_decode_top.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - rv_pkg.sv
  - control_unit.sv
  - sign_extend.sv
  - reg_file.sv
  - decode.sv
  - hazard_unit.sv
  - if_id_reg.sv
  - id_ex_reg.sv
  - decode_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_decode_top.sv
